// File: sources.f
+incdir+verilog
+incdir+dv
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/alu.sv
verilog/register_file.sv
verilog/control_fsm.sv
verilog/cpu_core.sv
dv/cpu_tb.sv

// File: Makefile
# Verilator flow for the cpu core

SIM_LOG = sim.log

all: sim

lint:
	verilator --lint-only --timing -f sources.f --top-module cpu_core

# the grep decides pass or fail
sim:
	verilator --binary --timing --assert -f sources.f --top-module cpu_tb -Mdir obj_dir
	./obj_dir/Vcpu_tb | tee $(SIM_LOG)
	grep -q "Regression passed" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)

.PHONY: all lint sim clean

// File: dv/isa_model.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// program layout, setup / preset / random body / register dump / loop
localparam int SETUP_REGS   = 6;
localparam int PRESET_ADDR  = SETUP_REGS + 1;
localparam int RANDOM_START = SETUP_REGS + 3;
localparam int RANDOM_LEN   = 20;
localparam int DUMP_START   = RANDOM_START + RANDOM_LEN;
localparam int PROG_LEN     = DUMP_START + 15;
localparam int MEM_WORDS    = 65536;
localparam int DATA_BASE    = 32'h8000;

logic [15:0] lfsr_state;
word_t       image [0:MEM_WORDS-1];
word_t       model_mem [0:MEM_WORDS-1];
word_t       model_regs [0:15];
mem_addr_t   exp_addr [$];
word_t       exp_data [$];
int          model_steps;

// galois lfsr, taps 16 14 13 11, one step per bit
function automatic word_t random_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
                v = {v[14:0], lfsr_state[0]};
                lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
        end
        return v;
endfunction

function automatic word_t encode(input opcode_t op, input logic [3:0] c,
                                 input logic [3:0] b, input logic [3:0] a);
        return {op, c, b, a};
endfunction

// r0 and r1 are never written by random code
function automatic logic [3:0] dest_reg(input logic [3:0] n);
        return (n < 4'd2) ? n + 4'd2 : n;
endfunction

// forward targets never pass the register dump
function automatic word_t random_instr(input int p);
        opcode_t    op;
        logic [3:0] c;
        logic [3:0] b;
        logic [3:0] a;
        int         limit;
        word_t      ir;
        op = opcode_t'(4'(random_bits(4)));
        c = 4'(random_bits(4));
        b = 4'(random_bits(4));
        a = 4'(random_bits(4));
        limit = DUMP_START - p;
        if (limit > 15) begin
                limit = 15;
        end
        case (op)
                ADD, ADDI, SUB, SUBI, LT, NAND: ir = encode(op, dest_reg(c), b, a);
                // data region only, base in r1
                LW: ir = encode(op, dest_reg(c), 4'd1, a);
                SW: ir = encode(op, c, 4'd1, a);
                BEQ, BLT: begin
                        // half of the BEQs compare a register with itself
                        if (op == BEQ) begin
                                if (random_bits(1) != '0) begin
                                        b = c;
                                end
                        end
                        ir = encode(op, c, b, 4'(1 + int'(a) % limit));
                end
                JUMP: ir = {JUMP, 12'(1 + int'(a) % limit)};
                // reserved codes, any fields
                default: ir = encode(op, c, b, a);
        endcase
        return ir;
endfunction

task automatic build_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
                image[i] = word_t'(i) ^ 16'h5A5A;
        end
        for (int i = 0; i < 16; i++) begin
                image[DATA_BASE + i] = random_bits(16);
        end
        // r2 and up from r0 plus a small immediate
        for (int r = 2; r < SETUP_REGS + 2; r++) begin
                image[r - 2] = encode(ADDI, 4'(r), 4'd0, 4'(random_bits(4)));
        end
        // hop over the preset word, then load r1 from it
        image[SETUP_REGS] = {JUMP, 12'd2};
        image[PRESET_ADDR] = 16'h8000;
        image[PRESET_ADDR + 1] = encode(LW, 4'd1, 4'd0, 4'(PRESET_ADDR));
        for (int p = RANDOM_START; p < DUMP_START; p++) begin
                image[p] = random_instr(p);
        end
        // r2..r15 to 0x8002..0x800F
        for (int r = 2; r < 16; r++) begin
                image[DUMP_START + r - 2] = encode(SW, 4'(r), 4'd1, 4'(r));
        end
        // loop in place
        image[PROG_LEN - 1] = {JUMP, 12'd0};
endtask

// instruction level model, stops at the jump to itself
task automatic run_model();
        mem_addr_t pc;
        mem_addr_t next_pc;
        mem_addr_t ea;
        word_t     ir;
        opcode_t   op;
        reg_addr_t a;
        reg_addr_t b;
        reg_addr_t c;
        imm_t      imm;
        model_mem = image;
        for (int i = 0; i < 16; i++) begin
                model_regs[i] = '0;
        end
        exp_addr.delete();
        exp_data.delete();
        pc = '0;
        model_steps = 0;
        while (model_steps < 2 * PROG_LEN) begin
                ir = model_mem[pc];
                if (ir == {JUMP, 12'd0}) begin
                        break;
                end
                op = opcode_t'(ir[15:12]);
                c = ir[11:8];
                b = ir[7:4];
                a = ir[3:0];
                imm = ir[3:0];
                ea = model_regs[b] + word_t'(imm);
                next_pc = pc + 16'd1;
                case (op)
                        ADD:  model_regs[c] = model_regs[b] + model_regs[a];
                        ADDI: model_regs[c] = model_regs[b] + word_t'(imm);
                        SUB:  model_regs[c] = model_regs[b] - model_regs[a];
                        SUBI: model_regs[c] = model_regs[b] - word_t'(imm);
                        NAND: model_regs[c] = ~(model_regs[b] & model_regs[a]);
                        LT:   model_regs[c] = (model_regs[b] < model_regs[a]) ? 16'd1 : 16'd0;
                        LW:   model_regs[c] = model_mem[ea];
                        SW: begin
                                model_mem[ea] = model_regs[c];
                                exp_addr.push_back(ea);
                                exp_data.push_back(model_regs[c]);
                        end
                        BEQ: begin
                                if (model_regs[c] == model_regs[b]) begin
                                        next_pc = pc + mem_addr_t'(imm);
                                end
                        end
                        BLT: begin
                                if (model_regs[b] < model_regs[c]) begin
                                        next_pc = pc + mem_addr_t'(imm);
                                end
                        end
                        JUMP: next_pc = pc + {{4{ir[11]}}, ir[11:0]};
                        default: begin
                        end
                endcase
                pc = next_pc;
                model_steps++;
        end
endtask

`endif

// File: dv/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;

        import isa_pkg::*;

        localparam int NUM_PROGRAMS = 4;
        localparam int RESET_CYCLES = 16;
        localparam int CLK_PERIOD   = 100;

        `include "isa_model.svh"

        localparam mem_addr_t LOOP_ADDR   = mem_addr_t'(PROG_LEN - 1);
        // worst case five cycles per instruction, twice over
        localparam int        WATCHDOG_NS = NUM_PROGRAMS * PROG_LEN * 5 * 2 * CLK_PERIOD;

        logic      clk;
        logic      reset;
        word_t     sram_d;
        mem_addr_t sram_addr;
        word_t     sram_q;
        logic      sram_we_n;
        word_t     sram [0:MEM_WORDS-1];

        int store_idx;
        int store_errors;
        int check_errors;
        int failed_tests;

        cpu_core DUT (
                .clk       (clk),
                .reset     (reset),
                .sram_d    (sram_d),
                .sram_addr (sram_addr),
                .sram_q    (sram_q),
                .sram_we_n (sram_we_n)
        );

        always #(CLK_PERIOD / 2) clk = ~clk;

        // async sram, combinational read
        assign sram_d = sram[sram_addr];

        // write at the rising edge, core never samples sram_d in that cycle
        always @(posedge clk) begin
                if (reset === 1'b1 && sram_we_n === 1'b0) begin
                        sram[sram_addr] = sram_q;
                end
        end

        // store monitor, mid cycle
        always @(negedge clk) begin
                if (reset !== 1'b1) begin
                        store_idx <= 0;
                end else if (sram_we_n === 1'b0) begin
                        assert (store_idx < exp_addr.size()) else begin
                                $display("ERROR: extra store at time %0t to %h, model made %0d",
                                         $time, sram_addr, exp_addr.size());
                                store_errors++;
                        end
                        if (store_idx < exp_addr.size()) begin
                                assert (sram_addr === exp_addr[store_idx]) else begin
                                        $display("FAIL time %0t sram_addr got %h expected %h",
                                                 $time, sram_addr, exp_addr[store_idx]);
                                        store_errors++;
                                end
                                assert (sram_q === exp_data[store_idx]) else begin
                                        $display("FAIL time %0t sram_q got %h expected %h",
                                                 $time, sram_q, exp_data[store_idx]);
                                        store_errors++;
                                end
                        end
                        store_idx <= store_idx + 1;
                end
        end

        // no write pending, address at the reset vector
        task automatic check_reset_outputs(input string phase);
                assert (sram_we_n === 1'b1) else begin
                        $display("FAIL time %0t sram_we_n got %b expected 1 %s",
                                 $time, sram_we_n, phase);
                        check_errors++;
                end
                assert (sram_addr === '0) else begin
                        $display("FAIL time %0t sram_addr got %h expected 0000 %s",
                                 $time, sram_addr, phase);
                        check_errors++;
                end
        endtask

        task automatic run_program(input int n);
                int errors_before;
                int waited;
                int settled;
                errors_before = check_errors + store_errors;
                @(posedge clk);
                reset <= 1'b0;
                build_program();
                sram = image;
                run_model();
                repeat (RESET_CYCLES) begin
                        @(negedge clk);
                        check_reset_outputs("in reset");
                end
                @(posedge clk);
                reset <= 1'b1;
                @(negedge clk);
                check_reset_outputs("after reset");
                // done once the core sits in the final loop
                waited = 0;
                settled = 0;
                while (settled < 4 && waited < PROG_LEN * 10) begin
                        @(negedge clk);
                        waited++;
                        settled = (sram_addr === LOOP_ADDR) ? settled + 1 : 0;
                end
                assert (settled >= 4) else begin
                        $display("ERROR: program %0d never reached its final loop in %0d cycles",
                                 n, waited);
                        check_errors++;
                end
                assert (store_idx == exp_addr.size()) else begin
                        $display("ERROR: program %0d made %0d stores but the model made %0d",
                                 n, store_idx, exp_addr.size());
                        check_errors++;
                end
                if (check_errors + store_errors == errors_before) begin
                        $display("program %0d: %0d instructions, %0d stores, ok",
                                 n, model_steps, exp_addr.size());
                end else begin
                        failed_tests++;
                        $display("program %0d: %0d instructions, %0d stores, %0d errors",
                                 n, model_steps, exp_addr.size(),
                                 check_errors + store_errors - errors_before);
                end
        endtask

        initial begin
                clk = 1'b0;
                reset <= 1'b0;
                lfsr_state = 16'd50381;
                for (int n = 0; n < NUM_PROGRAMS; n++) begin
                        run_program(n);
                end
                $display("%0d programs, %0d failed, %0d errors",
                         NUM_PROGRAMS, failed_tests, check_errors + store_errors);
                if (failed_tests == 0 && check_errors + store_errors == 0) begin
                        $display("Regression passed");
                end else begin
                        $display("Regression failed");
                end
                $finish;
        end

        // watchdog
        initial begin
                #(WATCHDOG_NS);
                $display("ERROR: watchdog expired after %0d ns", WATCHDOG_NS);
                $display("Regression failed");
                $finish;
        end

endmodule

`default_nettype wire

// File: verilog/cpu_core.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_core (
        input  wire                  clk,
        input  wire                  reset,
        input  wire isa_pkg::word_t  sram_d,
        output isa_pkg::mem_addr_t   sram_addr,
        output isa_pkg::word_t       sram_q,
        output logic                 sram_we_n
);

        import isa_pkg::*;
        import core_pkg::*;

        // register file ports
        reg_addr_t reg_addr_a;
        reg_addr_t reg_addr_b;
        reg_addr_t reg_addr_c;
        logic      reg_we;
        word_t     reg_data_c;
        word_t     reg_a;
        word_t     reg_b;

        // alu ports
        alu_op_t   alu_op;
        word_t     alu_operand_a;
        word_t     alu_result;
        logic      alu_zero;

        // sequencing, pc and sram port
        control_fsm u_control (
                .clk           (clk),
                .reset         (reset),
                .sram_d        (sram_d),
                .reg_a         (reg_a),
                .reg_b         (reg_b),
                .alu_result    (alu_result),
                .alu_zero      (alu_zero),
                .sram_addr     (sram_addr),
                .sram_q        (sram_q),
                .sram_we_n     (sram_we_n),
                .reg_addr_a    (reg_addr_a),
                .reg_addr_b    (reg_addr_b),
                .reg_addr_c    (reg_addr_c),
                .reg_we        (reg_we),
                .reg_data_c    (reg_data_c),
                .alu_op        (alu_op),
                .alu_operand_a (alu_operand_a)
        );

        register_file u_regs (
                .clk        (clk),
                .reset      (reset),
                .reg_addr_a (reg_addr_a),
                .reg_addr_b (reg_addr_b),
                .reg_addr_c (reg_addr_c),
                .reg_we     (reg_we),
                .reg_data_c (reg_data_c),
                .reg_a      (reg_a),
                .reg_b      (reg_b)
        );

        // operand b always straight from port b
        alu u_alu (
                .alu_op    (alu_op),
                .operand_a (alu_operand_a),
                .operand_b (reg_b),
                .result    (alu_result),
                .zero      (alu_zero)
        );

endmodule

`default_nettype wire

// File: verilog/control_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module control_fsm (
        input  wire                    clk,
        input  wire                    reset,
        input  wire isa_pkg::word_t    sram_d,
        input  wire isa_pkg::word_t    reg_a,
        input  wire isa_pkg::word_t    reg_b,
        input  wire isa_pkg::word_t    alu_result,
        input  wire                    alu_zero,
        output isa_pkg::mem_addr_t     sram_addr,
        output isa_pkg::word_t         sram_q,
        output logic                   sram_we_n,
        output isa_pkg::reg_addr_t     reg_addr_a,
        output isa_pkg::reg_addr_t     reg_addr_b,
        output isa_pkg::reg_addr_t     reg_addr_c,
        output logic                   reg_we,
        output isa_pkg::word_t         reg_data_c,
        output core_pkg::alu_op_t      alu_op,
        output isa_pkg::word_t         alu_operand_a
);

        import isa_pkg::*;
        import core_pkg::*;

        fsm_state_t   state;
        fsm_state_t   state_next;
        mem_addr_t    pc;
        word_t        instr;
        logic         branch_taken;
        logic         branch_cond;
        logic         imm_sel;
        opcode_t      opcode;
        reg_addr_t    op1;
        reg_addr_t    op2;
        reg_addr_t    op3;
        imm_t         imm;
        jump_offset_t jump_offset;
        mem_addr_t    pc_inc;
        mem_addr_t    pc_branch;
        mem_addr_t    pc_jump;

        // instruction fields
        assign opcode      = opcode_t'(instr[15:12]);
        assign op1         = instr[3:0];
        assign op2         = instr[7:4];
        assign op3         = instr[11:8];
        assign imm         = instr[3:0];
        assign jump_offset = instr[11:0];

        // pc candidates
        assign pc_inc    = pc + mem_addr_t'(1);
        assign pc_branch = pc + mem_addr_t'(imm);
        // offset is sign extended by the cast
        assign pc_jump   = pc + mem_addr_t'(jump_offset);

        // BEQ uses the subtract zero flag and BLT the lt bit
        assign branch_cond = (opcode == BEQ) ? alu_zero : alu_result[0];

        // load data bypasses the alu
        assign reg_data_c = (state == LOAD_DATA) ? sram_d : alu_result;

        // zero extended immediate replaces ra
        assign alu_operand_a = imm_sel ? word_t'(imm) : reg_a;

        // next state
        always_comb begin
                state_next = FETCH;
                case (state)
                        FETCH:       state_next = DECODE;
                        DECODE: begin
                                case (opcode)
                                        ADD, ADDI, SUB, SUBI, LT, NAND: state_next = ALU_EXEC;
                                        LW:       state_next = LOAD_ADDR;
                                        SW:       state_next = STORE_ADDR;
                                        BLT, BEQ: state_next = BRANCH_TEST;
                                        JUMP:     state_next = JUMP_EXEC;
                                        // dropped opcodes
                                        default:  state_next = NOP_EXEC;
                                endcase
                        end
                        LOAD_ADDR:   state_next = LOAD_DATA;
                        STORE_ADDR:  state_next = STORE_WRITE;
                        STORE_WRITE: state_next = STORE_DONE;
                        BRANCH_TEST: state_next = BRANCH_TAKE;
                        default:     state_next = FETCH;
                endcase
        end

        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        state <= FETCH;
                end else begin
                        state <= state_next;
                end
        end

        // latched in FETCH where sram_addr already holds pc
        always_ff @(posedge clk) begin
                if (state == FETCH) begin
                        instr <= sram_d;
                end
        end

        // pc and sram port registers
        // sram_addr follows every pc change in the same edge
        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        pc           <= '0;
                        sram_addr    <= '0;
                        sram_q       <= '0;
                        sram_we_n    <= 1'b1;
                        branch_taken <= 1'b0;
                end else begin
                        case (state)
                                ALU_EXEC, NOP_EXEC, LOAD_DATA, STORE_DONE: begin
                                        pc        <= pc_inc;
                                        sram_addr <= pc_inc;
                                end
                                JUMP_EXEC: begin
                                        pc        <= pc_jump;
                                        sram_addr <= pc_jump;
                                end
                                // compare is registered and pc moves next cycle
                                BRANCH_TEST: branch_taken <= branch_cond;
                                BRANCH_TAKE: begin
                                        pc        <= branch_taken ? pc_branch : pc_inc;
                                        sram_addr <= branch_taken ? pc_branch : pc_inc;
                                end
                                // effective address rb + imm
                                LOAD_ADDR: sram_addr <= mem_addr_t'(alu_result);
                                STORE_ADDR: begin
                                        sram_addr <= mem_addr_t'(alu_result);
                                        sram_q    <= reg_a;
                                        // low for STORE_WRITE only
                                        sram_we_n <= 1'b0;
                                end
                                STORE_WRITE: sram_we_n <= 1'b1;
                                default: begin
                                end
                        endcase
                end
        end

        // register addresses, alu function and operand select per state
        always_comb begin
                reg_addr_a = op1;
                reg_addr_b = op2;
                reg_addr_c = op3;
                reg_we     = 1'b0;
                alu_op     = ALU_ADD;
                imm_sel    = 1'b0;
                case (state)
                        ALU_EXEC: begin
                                reg_we = 1'b1;
                                case (opcode)
                                        SUB, SUBI: alu_op = ALU_SUB;
                                        NAND:      alu_op = ALU_NAND;
                                        LT:        alu_op = ALU_LT;
                                        default:   alu_op = ALU_ADD;
                                endcase
                                imm_sel = (opcode == ADDI) || (opcode == SUBI);
                        end
                        LOAD_ADDR: imm_sel = 1'b1;
                        LOAD_DATA: reg_we = 1'b1;
                        // op3 holds the store data and goes through port a
                        STORE_ADDR: begin
                                reg_addr_a = op3;
                                imm_sel    = 1'b1;
                        end
                        // b is reg[op2] and a is reg[op3]
                        BRANCH_TEST: begin
                                reg_addr_a = op3;
                                alu_op     = (opcode == BEQ) ? ALU_SUB : ALU_LT;
                        end
                        default: begin
                        end
                endcase
        end

endmodule

`default_nettype wire

// File: verilog/register_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module register_file (
        input  wire                     clk,
        input  wire                     reset,
        input  wire isa_pkg::reg_addr_t reg_addr_a,
        input  wire isa_pkg::reg_addr_t reg_addr_b,
        input  wire isa_pkg::reg_addr_t reg_addr_c,
        input  wire                     reg_we,
        input  wire isa_pkg::word_t     reg_data_c,
        output isa_pkg::word_t          reg_a,
        output isa_pkg::word_t          reg_b
);

        import isa_pkg::*;

        word_t regs [`NUM_REGS];

        // one write port, registered
        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        for (int i = 0; i < `NUM_REGS; i++) begin
                                regs[i] <= '0;
                        end
                end else if (reg_we) begin
                        regs[reg_addr_c] <= reg_data_c;
                end
        end

        // asynchronous reads
        assign reg_a = regs[reg_addr_a];
        assign reg_b = regs[reg_addr_b];

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
        input  wire core_pkg::alu_op_t alu_op,
        input  wire isa_pkg::word_t    operand_a,
        input  wire isa_pkg::word_t    operand_b,
        output isa_pkg::word_t         result,
        output logic                   zero
);

        import core_pkg::*;

        // b is the first source, a the second
        always_comb begin
                case (alu_op)
                        ALU_ADD:  result = operand_b + operand_a;
                        ALU_SUB:  result = operand_b - operand_a;
                        ALU_NAND: result = ~(operand_b & operand_a);
                        // unsigned compare, 0 or 1
                        ALU_LT: begin
                                result    = '0;
                                result[0] = operand_b < operand_a;
                        end
                        default:  result = '0;
                endcase
        end

        // equality test for BEQ after subtract
        assign zero = (result == '0);

endmodule

`default_nettype wire

// File: verilog/core_pkg.sv
`default_nettype none

package core_pkg;

        // control states, every instruction starts in FETCH
        typedef enum logic [3:0] {
                FETCH       = 4'd0,
                DECODE      = 4'd1,
                ALU_EXEC    = 4'd2,
                LOAD_ADDR   = 4'd3,
                LOAD_DATA   = 4'd4,
                STORE_ADDR  = 4'd5,
                STORE_WRITE = 4'd6,
                STORE_DONE  = 4'd7,
                BRANCH_TEST = 4'd8,
                BRANCH_TAKE = 4'd9,
                JUMP_EXEC   = 4'd10,
                NOP_EXEC    = 4'd11
        } fsm_state_t;

        // alu functions, result = b op a
        typedef enum logic [1:0] {
                ALU_ADD  = 2'd0,
                ALU_SUB  = 2'd1,
                ALU_NAND = 2'd2,
                ALU_LT   = 2'd3
        } alu_op_t;

endpackage

`default_nettype wire

// File: verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

        `include "cpu_settings.svh"

        // one data word, also the instruction word
        typedef logic [`WORD_WIDTH-1:0] word_t;

        // sram address, also the pc
        typedef logic [`ADDR_WIDTH-1:0] mem_addr_t;

        // register number, op1 / op2 / op3 fields
        typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

        // bits 3..0, unsigned immediate or forward branch offset
        typedef logic [3:0] imm_t;

        // bits 11..0, signed jump offset
        typedef logic signed [11:0] jump_offset_t;

        // bits 15..12
        // reserved codes execute as no-ops
        typedef enum logic [3:0] {
                ADD     = 4'd0,
                ADDI    = 4'd1,
                SUB     = 4'd2,
                SUBI    = 4'd3,
                RSVD_4  = 4'd4,
                SW      = 4'd5,
                LW      = 4'd6,
                LT      = 4'd7,
                NAND    = 4'd8,
                RSVD_9  = 4'd9,
                RSVD_10 = 4'd10,
                RSVD_11 = 4'd11,
                BLT     = 4'd12,
                RSVD_13 = 4'd13,
                BEQ     = 4'd14,
                JUMP    = 4'd15
        } opcode_t;

endpackage

`default_nettype wire

// File: verilog/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data path word, one sram word per address
`define WORD_WIDTH 16

// sram address and pc width
`define ADDR_WIDTH 16

// register number field in the instruction
`define REG_ADDR_WIDTH 4

// general purpose registers, r0 included
`define NUM_REGS 16

`endif
